// File: hw/ledger_cfg.svh
// Ledger configuration: account count, key generator constants and register map
`ifndef LEDGER_CFG_SVH
`define LEDGER_CFG_SVH

// Account table
`define LEDGER_NUM_ACCOUNTS 6
`define LEDGER_ACCT_W 3
`define LEDGER_START_BALANCE 32'd1000

// Galois LFSR used for the per-account keys
`define LEDGER_KEY_SEED 16'hACE1
`define LEDGER_KEY_TAPS 16'hB400

// AXI4-Lite byte offsets, low nibble of the address
`define LEDGER_REG_AMOUNT 4'h0
`define LEDGER_REG_CMD 4'h4
`define LEDGER_REG_STATUS 4'h8
`define LEDGER_REG_BALANCE 4'hC

`endif

// File: hw/ledger_pkg.sv
// Ledger package holding the AXI4-Lite bundles, transaction records and result codes
`default_nettype none

`include "ledger_cfg.svh"

package ledger_pkg;

	typedef enum logic [1:0] {
		RESP_OKAY = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_e;

	// Master side of AW, W and B
	typedef struct packed {
		logic [31:0] awaddr;
		logic awvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
	} axil_wr_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		axi_resp_e bresp;
	} axil_wr_rsp_t;

	typedef struct packed {
		logic [31:0] araddr;
		logic arvalid;
		logic rready;
	} axil_rd_req_t;

	typedef struct packed {
		logic arready;
		logic [31:0] rdata;
		axi_resp_e rresp;
		logic rvalid;
	} axil_rd_rsp_t;

	typedef enum logic [1:0] {
		DEPOSIT = 2'd0,
		WITHDRAW = 2'd1,
		QUERY = 2'd2
	} txn_op_e;

	typedef enum logic [2:0] {
		OK = 3'd0,
		BAD_ACCOUNT = 3'd1,
		BAD_KEY = 3'd2,
		NO_FUNDS = 3'd3,
		OVERFLOW = 3'd4
	} txn_code_e;

	typedef struct packed {
		txn_op_e op;
		logic [`LEDGER_ACCT_W-1:0] account;
		logic [15:0] key;
		logic [31:0] amount;
	} txn_req_t;

	// One memory word
	typedef struct packed {
		logic [15:0] key;
		logic [31:0] balance;
	} account_rec_t;

	typedef struct packed {
		txn_code_e code;
		logic [31:0] balance;
	} txn_result_t;

	// CMD register layout, op in [1:0], account from bit 8, key in [31:16]
	typedef struct packed {
		logic [15:0] key;
		logic [7-`LEDGER_ACCT_W:0] rsvd1;
		logic [`LEDGER_ACCT_W-1:0] account;
		logic [5:0] rsvd0;
		txn_op_e op;
	} cmd_word_t;

	// STATUS register layout
	typedef struct packed {
		logic [24:0] rsvd1;
		txn_code_e code;    // Bits 6:4
		logic [1:0] rsvd0;
		logic busy;         // Bit 1
		logic ready;        // Bit 0
	} status_word_t;

	typedef enum logic [2:0] {
		ST_KEY_START,
		ST_INIT,
		ST_IDLE,
		ST_READ,
		ST_CHECK,
		ST_STORE,
		ST_POST
	} txn_state_e;

endpackage

`default_nettype wire

// File: hw/axil_regs.sv
// AXI4-Lite register block: amount register, command launch, status and balance readback
`default_nettype none

`include "ledger_cfg.svh"

module axil_regs import ledger_pkg::*; (
	input  logic         clock,
	input  logic         rst_n,
	input  axil_wr_req_t wr_req,
	output axil_wr_rsp_t wr_rsp,
	input  axil_rd_req_t rd_req,
	output axil_rd_rsp_t rd_rsp,
	output txn_req_t     cmd,
	output logic         cmd_valid,
	input  txn_result_t  result,
	input  logic         result_valid,
	input  logic         busy,
	input  logic         ready
);
	logic aw_seen;
	logic w_seen;
	logic [3:0] awaddr_q;
	logic [31:0] wdata_q;
	logic [3:0] wstrb_q;
	logic bvalid_q;
	axi_resp_e bresp_q;
	logic aw_fire;
	logic w_fire;
	logic wr_go;
	logic [3:0] wr_off;
	logic [31:0] wr_data;
	logic [3:0] wr_strb;
	cmd_word_t cmd_word;
	logic cmd_ok;
	logic [31:0] amount_q;
	txn_result_t last_q;
	status_word_t status;
	logic [31:0] rd_word;
	logic rvalid_q;
	logic [31:0] rdata_q;

	// Each channel closes once captured, reopens after the B handshake
	assign wr_rsp.awready = !aw_seen && !bvalid_q;
	assign wr_rsp.wready = !w_seen && !bvalid_q;
	assign wr_rsp.bvalid = bvalid_q;
	assign wr_rsp.bresp = bresp_q;

	assign aw_fire = wr_req.awvalid && wr_rsp.awready;
	assign w_fire = wr_req.wvalid && wr_rsp.wready;
	assign wr_go = (aw_seen || aw_fire) && (w_seen || w_fire);   // Later half arrives
	assign wr_off = aw_fire ? wr_req.awaddr[3:0] : awaddr_q;
	assign wr_data = w_fire ? wr_req.wdata : wdata_q;
	assign wr_strb = w_fire ? wr_req.wstrb : wstrb_q;
	assign cmd_word = cmd_word_t'(wr_data);
	assign cmd_ok = ready && !busy && !cmd_valid;   // Pending launch counts as busy

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			aw_seen <= 1'b0;
			w_seen <= 1'b0;
			bvalid_q <= 1'b0;
			bresp_q <= RESP_OKAY;
			cmd_valid <= 1'b0;
		end
		else
		begin
			cmd_valid <= 1'b0;
			if (wr_go)
			begin
				aw_seen <= 1'b0;
				w_seen <= 1'b0;
				bvalid_q <= 1'b1;
				case (wr_off)
					`LEDGER_REG_AMOUNT: bresp_q <= RESP_OKAY;
					`LEDGER_REG_CMD:
					begin
						cmd_valid <= cmd_ok;
						bresp_q <= cmd_ok ? RESP_OKAY : RESP_SLVERR;
					end
					default: bresp_q <= RESP_SLVERR;   // Read-only or unmapped
				endcase
			end
			else
			begin
				if (aw_fire)
					aw_seen <= 1'b1;
				if (w_fire)
					w_seen <= 1'b1;
			end
			if (bvalid_q && wr_req.bready)
				bvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (aw_fire)
			awaddr_q <= wr_req.awaddr[3:0];
		if (w_fire)
		begin
			wdata_q <= wr_req.wdata;
			wstrb_q <= wr_req.wstrb;
		end
		if (wr_go && wr_off == `LEDGER_REG_CMD && cmd_ok)
			cmd <= '{op: cmd_word.op, account: cmd_word.account, key: cmd_word.key,
				amount: amount_q};
	end

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			amount_q <= '0;
			last_q <= '{code: OK, balance: '0};
		end
		else
		begin
			if (wr_go && wr_off == `LEDGER_REG_AMOUNT)
				for (int b = 0; b < 4; b++)
					if (wr_strb[b])
						amount_q[8*b +: 8] <= wr_data[8*b +: 8];
			if (result_valid)
				last_q <= result;   // Kept for STATUS and BALANCE
		end
	end

	assign status = '{rsvd1: '0, code: last_q.code, rsvd0: '0, busy: busy, ready: ready};

	always_comb
	begin
		case (rd_req.araddr[3:0])
			`LEDGER_REG_AMOUNT: rd_word = amount_q;
			`LEDGER_REG_STATUS: rd_word = status;
			`LEDGER_REG_BALANCE: rd_word = last_q.balance;
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!rst_n)
			rvalid_q <= 1'b0;
		else if (rd_req.arvalid && rd_rsp.arready)
			rvalid_q <= 1'b1;
		else if (rd_req.rready)
			rvalid_q <= 1'b0;
	end

	always_ff @(posedge clock)
	begin
		if (rd_req.arvalid && rd_rsp.arready)
			rdata_q <= rd_word;
	end

	assign rd_rsp.arready = !rvalid_q;   // One read in flight
	assign rd_rsp.rdata = rdata_q;
	assign rd_rsp.rresp = RESP_OKAY;
	assign rd_rsp.rvalid = rvalid_q;

endmodule

`default_nettype wire

// File: hw/txn_control.sv
// Ledger controller that fills the account memory at start-up and then runs each transaction
`default_nettype none

`include "ledger_cfg.svh"

module txn_control import ledger_pkg::*; (
	input  logic                      clock,
	input  logic                      rst_n,
	input  txn_req_t                  cmd,
	input  logic                      cmd_valid,
	input  logic [15:0]               key,
	input  logic                      key_valid,
	output logic                      key_start,
	output logic [`LEDGER_ACCT_W-1:0] ram_waddr,
	output logic [`LEDGER_ACCT_W-1:0] ram_raddr,
	output logic                      ram_we,
	output account_rec_t              ram_wdata,
	output logic                      chk_en,
	output txn_req_t                  chk_req,
	input  account_rec_t              chk_new,
	input  txn_result_t               chk_result,
	output txn_result_t               result,
	output logic                      result_valid,
	output logic                      busy,
	output logic                      ready
);
	txn_state_e state;
	txn_req_t req_q;
	logic [`LEDGER_ACCT_W-1:0] init_idx;
	logic in_init;
	logic bad_acct;
	logic store_ok;

	assign in_init = (state == ST_INIT);
	assign bad_acct = int'(req_q.account) >= `LEDGER_NUM_ACCOUNTS;

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			state <= ST_KEY_START;
			init_idx <= '0;
		end
		else
		begin
			case (state)
				ST_KEY_START: state <= ST_INIT;
				ST_INIT:
				begin
					if (key_valid)
					begin
						init_idx <= init_idx + 1'b1;
						if (int'(init_idx) == `LEDGER_NUM_ACCOUNTS - 1)
							state <= ST_IDLE;
					end
				end
				ST_IDLE:
				begin
					if (cmd_valid)
						state <= ST_READ;
				end
				ST_READ: state <= ST_CHECK;     // RAM registers the record
				ST_CHECK: state <= ST_STORE;    // Datapath registers the verdict
				ST_STORE: state <= ST_POST;
				ST_POST: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == ST_IDLE && cmd_valid)
			req_q <= cmd;
	end

	assign key_start = (state == ST_KEY_START);

	// Out-of-range accounts never reach the memory or the datapath
	assign ram_raddr = bad_acct ? '0 : req_q.account;
	assign chk_en = (state == ST_CHECK) && !bad_acct;
	assign chk_req = req_q;

	assign store_ok = (state == ST_STORE) && !bad_acct && chk_result.code == OK
		&& req_q.op != QUERY;
	assign ram_we = (in_init && key_valid) || store_ok;
	assign ram_waddr = in_init ? init_idx : req_q.account;
	assign ram_wdata = in_init ? account_rec_t'{key: key, balance: `LEDGER_START_BALANCE}
		: chk_new;

	always_comb
	begin
		if (bad_acct)
			result = '{code: BAD_ACCOUNT, balance: '0};
		else
			result = chk_result;
	end

	assign result_valid = (state == ST_POST);
	assign busy = (state == ST_READ) || (state == ST_CHECK) || (state == ST_STORE);
	assign ready = (state != ST_KEY_START) && !in_init;

endmodule

`default_nettype wire

// File: hw/key_table.sv
// Key generator: Galois LFSR that emits one 16-bit key per account every 16 steps
`default_nettype none

`include "ledger_cfg.svh"

module key_table (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        start,
	output logic [15:0] key,
	output logic        key_valid
);
	logic [15:0] lfsr_q;
	logic [15:0] lfsr_d;
	logic [3:0] step_cnt;
	logic [`LEDGER_ACCT_W-1:0] key_cnt;
	logic running;

	// Shift right, fold taps back in when a one falls out
	assign lfsr_d = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? `LEDGER_KEY_TAPS : 16'h0000);

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			running <= 1'b0;
			step_cnt <= '0;
			key_cnt <= '0;
			key_valid <= 1'b0;
		end
		else
		begin
			key_valid <= 1'b0;
			if (start)
			begin
				running <= 1'b1;
				step_cnt <= '0;
				key_cnt <= '0;
			end
			else if (running)
			begin
				step_cnt <= step_cnt + 1'b1;
				if (step_cnt == 4'd15)
				begin
					key_valid <= 1'b1;
					key_cnt <= key_cnt + 1'b1;
					if (int'(key_cnt) == `LEDGER_NUM_ACCOUNTS - 1)
						running <= 1'b0;   // Last account done
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (start)
			lfsr_q <= `LEDGER_KEY_SEED;
		else if (running)
			lfsr_q <= lfsr_d;
		if (running && step_cnt == 4'd15)
			key <= lfsr_d;   // State after the 16th step
	end

endmodule

`default_nettype wire

// File: hw/account_ram.sv
// Account memory: one record per account, registered read port and separate write port
`default_nettype none

`include "ledger_cfg.svh"

module account_ram import ledger_pkg::*; (
	input  logic                      clock,
	input  logic                      we,
	input  logic [`LEDGER_ACCT_W-1:0] waddr,
	input  account_rec_t              wdata,
	input  logic [`LEDGER_ACCT_W-1:0] raddr,
	output account_rec_t              rdata
);
	account_rec_t mem [`LEDGER_NUM_ACCOUNTS];

	// Write port
	always_ff @(posedge clock)
	begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Same-cycle write and read return the old record
	always_ff @(posedge clock)
	begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// File: hw/balance_datapath.sv
// Balance datapath: checks key, funds and overflow and registers the new balance and code
`default_nettype none

module balance_datapath import ledger_pkg::*; (
	input  logic         clock,
	input  logic         rst_n,
	input  logic         en,
	input  txn_req_t     req,
	input  account_rec_t rec,
	output account_rec_t new_rec,
	output txn_result_t  result
);
	logic [32:0] sum;
	logic [32:0] diff;
	txn_code_e code_d;
	logic [31:0] bal_d;

	assign sum = {1'b0, rec.balance} + {1'b0, req.amount};   // Bit 32 is the carry
	assign diff = {1'b0, rec.balance} - {1'b0, req.amount};  // Bit 32 is the borrow

	always_comb
	begin
		code_d = OK;
		bal_d = rec.balance;
		if (req.key != rec.key)
			code_d = BAD_KEY;
		else
		begin
			case (req.op)
				DEPOSIT:
				begin
					if (sum[32])
						code_d = OVERFLOW;
					else
						bal_d = sum[31:0];
				end
				WITHDRAW:
				begin
					if (diff[32])
						code_d = NO_FUNDS;
					else
						bal_d = diff[31:0];
				end
				default: bal_d = rec.balance;   // Query and unused op
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rst_n)
			result <= '{code: OK, balance: '0};
		else if (en)
			result <= '{code: code_d, balance: bal_d};
	end

	always_ff @(posedge clock)
	begin
		if (en)
			new_rec <= '{key: rec.key, balance: bal_d};
	end

endmodule

`default_nettype wire

// File: hw/ledger_top.sv
// Ledger top level: AXI4-Lite registers, controller, key generator, memory and datapath
`default_nettype none

`include "ledger_cfg.svh"

module ledger_top import ledger_pkg::*; (
	input  logic         clock,
	input  logic         rst_n,
	input  axil_wr_req_t wr_req,
	output axil_wr_rsp_t wr_rsp,
	input  axil_rd_req_t rd_req,
	output axil_rd_rsp_t rd_rsp
);
	txn_req_t cmd;
	logic cmd_valid;
	txn_result_t result;
	logic result_valid;
	logic busy;
	logic ready;
	logic key_start;
	logic [15:0] key;
	logic key_valid;
	logic ram_we;
	logic [`LEDGER_ACCT_W-1:0] ram_waddr;
	logic [`LEDGER_ACCT_W-1:0] ram_raddr;
	account_rec_t ram_wdata;
	account_rec_t ram_rdata;
	logic chk_en;
	txn_req_t chk_req;
	account_rec_t chk_new;
	txn_result_t chk_result;

	axil_regs regs_i (
		.clock(clock), .rst_n(rst_n),
		.wr_req(wr_req), .wr_rsp(wr_rsp), .rd_req(rd_req), .rd_rsp(rd_rsp),
		.cmd(cmd), .cmd_valid(cmd_valid),
		.result(result), .result_valid(result_valid),
		.busy(busy), .ready(ready)
	);

	txn_control ctrl_i (
		.clock(clock), .rst_n(rst_n),
		.cmd(cmd), .cmd_valid(cmd_valid),
		.key(key), .key_valid(key_valid), .key_start(key_start),
		.ram_waddr(ram_waddr), .ram_raddr(ram_raddr), .ram_we(ram_we), .ram_wdata(ram_wdata),
		.chk_en(chk_en), .chk_req(chk_req), .chk_new(chk_new), .chk_result(chk_result),
		.result(result), .result_valid(result_valid),
		.busy(busy), .ready(ready)
	);

	key_table keys_i (
		.clock(clock), .rst_n(rst_n),
		.start(key_start), .key(key), .key_valid(key_valid)
	);

	account_ram ram_i (
		.clock(clock),
		.we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
		.raddr(ram_raddr), .rdata(ram_rdata)
	);

	balance_datapath dp_i (
		.clock(clock), .rst_n(rst_n),
		.en(chk_en), .req(chk_req), .rec(ram_rdata),
		.new_rec(chk_new), .result(chk_result)
	);

endmodule

`default_nettype wire

// File: testbench/ledger_assertions.sv
// Ledger protocol checks on AXI4-Lite response hold, store timing and command launch
`default_nettype none

module ledger_assertions import ledger_pkg::*; (
	input logic         clock,
	input logic         rst_n,
	input axil_wr_req_t wr_req,
	input axil_wr_rsp_t wr_rsp,
	input axil_rd_req_t rd_req,
	input axil_rd_rsp_t rd_rsp,
	input logic         cmd_valid,
	input logic         ram_we,
	input logic         busy,
	input logic         ready
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;   // Failed assertions so far

	bvalid_hold: assert property (@(posedge clock) disable iff (!rst_n)
		wr_rsp.bvalid && !wr_req.bready |=> wr_rsp.bvalid && $stable(wr_rsp.bresp))
	else
	begin
		$error("bvalid or bresp changed before bready");
		fail_count++;
	end

	rvalid_hold: assert property (@(posedge clock) disable iff (!rst_n)
		rd_rsp.rvalid && !rd_req.rready |=> rd_rsp.rvalid && $stable(rd_rsp.rdata))
	else
	begin
		$error("rvalid or rdata changed before rready");
		fail_count++;
	end

	// After init a record is stored only in the store phase, three cycles after launch
	ram_write_window: assert property (@(posedge clock) disable iff (!rst_n)
		ram_we && ready |-> $past(cmd_valid, 3))
	else
	begin
		$error("account memory written outside init and store");
		fail_count++;
	end

	// A launched command always finds the controller alive and idle
	status_alive: assert property (@(posedge clock) disable iff (!rst_n)
		cmd_valid |=> busy && ready)
	else
	begin
		$error("controller not busy and ready after a command launch");
		fail_count++;
	end

endmodule

bind ledger_top ledger_assertions assert_i (
	.clock(clock),
	.rst_n(rst_n),
	.wr_req(wr_req),
	.wr_rsp(wr_rsp),
	.rd_req(rd_req),
	.rd_rsp(rd_rsp),
	.cmd_valid(cmd_valid),
	.ram_we(ram_we),
	.busy(busy),
	.ready(ready)
);

`default_nettype wire

// File: testbench/tb_ledger.sv
// Ledger testbench that runs a table of transactions over AXI4-Lite against a ledger model
`default_nettype none

`include "ledger_cfg.svh"

module tb_ledger import ledger_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HANDSHAKE_TIMEOUT = 40;   // Cycles per channel handshake
	localparam int POLL_LIMIT = 200;         // STATUS reads before giving up
	localparam logic [31:0] RAND_SEED = 32'd84565;
	localparam logic [31:0] RAND_TAPS = 32'h8020_0003;

	typedef enum logic [1:0] {
		KEY_RIGHT,
		KEY_WRONG,
		KEY_RANDOM
	} key_sel_e;

	typedef struct packed {
		txn_op_e op;
		logic [`LEDGER_ACCT_W-1:0] acct;
		key_sel_e key_sel;
		logic [31:0] amount;
		logic rand_amount;
		txn_code_e exp_code;
	} row_t;

	localparam int NUM_ROWS = 25;
	localparam row_t ROWS [NUM_ROWS] = '{
		'{QUERY, 3'd0, KEY_RIGHT, 32'd0, 1'b0, OK},
		'{QUERY, 3'd1, KEY_RIGHT, 32'd0, 1'b0, OK},
		'{QUERY, 3'd2, KEY_RIGHT, 32'd0, 1'b0, OK},
		'{QUERY, 3'd3, KEY_RIGHT, 32'd0, 1'b0, OK},
		'{QUERY, 3'd4, KEY_RIGHT, 32'd0, 1'b0, OK},
		'{QUERY, 3'd5, KEY_RIGHT, 32'd0, 1'b0, OK},
		'{DEPOSIT, 3'd0, KEY_RIGHT, 32'd250, 1'b0, OK},
		'{WITHDRAW, 3'd0, KEY_RIGHT, 32'd300, 1'b0, OK},
		'{QUERY, 3'd0, KEY_RIGHT, 32'd0, 1'b0, OK},
		'{DEPOSIT, 3'd3, KEY_RIGHT, 32'd0, 1'b1, OK},
		'{QUERY, 3'd3, KEY_RIGHT, 32'd0, 1'b0, OK},
		'{WITHDRAW, 3'd1, KEY_WRONG, 32'd100, 1'b0, BAD_KEY},
		'{DEPOSIT, 3'd2, KEY_RANDOM, 32'd50, 1'b0, BAD_KEY},
		'{QUERY, 3'd1, KEY_RIGHT, 32'd0, 1'b0, OK},
		'{QUERY, 3'd2, KEY_RIGHT, 32'd0, 1'b0, OK},
		'{WITHDRAW, 3'd4, KEY_RIGHT, 32'd5000, 1'b0, NO_FUNDS},
		'{DEPOSIT, 3'd5, KEY_RIGHT, 32'hFFFF_FF00, 1'b0, OVERFLOW},
		'{QUERY, 3'd4, KEY_RIGHT, 32'd0, 1'b0, OK},
		'{QUERY, 3'd5, KEY_RIGHT, 32'd0, 1'b0, OK},
		'{DEPOSIT, 3'd5, KEY_RIGHT, 32'hFFFF_FC17, 1'b0, OK},   // Lands on all ones
		'{DEPOSIT, 3'd5, KEY_RIGHT, 32'd1, 1'b0, OVERFLOW},
		'{QUERY, 3'd6, KEY_WRONG, 32'd0, 1'b0, BAD_ACCOUNT},
		'{DEPOSIT, 3'd7, KEY_WRONG, 32'd10, 1'b0, BAD_ACCOUNT},
		'{WITHDRAW, 3'd4, KEY_RIGHT, 32'd1000, 1'b0, OK},
		'{WITHDRAW, 3'd4, KEY_RIGHT, 32'd1, 1'b0, NO_FUNDS}
	};

	logic clock;
	logic rst_n;
	axil_wr_req_t wr_req;
	axil_wr_rsp_t wr_rsp;
	axil_rd_req_t rd_req;
	axil_rd_rsp_t rd_rsp;
	logic [15:0] model_key [`LEDGER_NUM_ACCOUNTS];
	logic [31:0] model_bal [`LEDGER_NUM_ACCOUNTS];
	logic [31:0] rnd_state;
	bit timed_out;
	int err_count;
	int test_count;
	int pass_count;

	ledger_top dut_i (
		.clock(clock), .rst_n(rst_n),
		.wr_req(wr_req), .wr_rsp(wr_rsp), .rd_req(rd_req), .rd_rsp(rd_rsp)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Ends the run after a handshake or poll timeout
	initial
	begin
		wait (timed_out);
		$display("TESTS FAILED");
		$finish;
	end

	// Key rule with 16 Galois steps per account from the seed
	function automatic logic [15:0] key_after_steps(input int steps);
		logic [15:0] s;
		s = `LEDGER_KEY_SEED;
		for (int n = 0; n < steps; n++)
			s = s[0] ? ((s >> 1) ^ `LEDGER_KEY_TAPS) : (s >> 1);
		return s;
	endfunction

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < count; i++)
		begin
			rnd_state = rnd_state[0] ? ((rnd_state >> 1) ^ RAND_TAPS) : (rnd_state >> 1);
			v = {v[30:0], rnd_state[0]};   // One bit per step
		end
		return v;
	endfunction

	function automatic logic [15:0] pick_key(input row_t r);
		logic [15:0] right;
		logic [31:0] draw;
		logic [15:0] k;
		right = (int'(r.acct) < `LEDGER_NUM_ACCOUNTS) ? model_key[r.acct] : 16'h5A5A;
		k = right;
		if (r.key_sel == KEY_WRONG)
			k = right ^ 16'hFFFF;
		else if (r.key_sel == KEY_RANDOM)
		begin
			draw = random_bits(16);
			k = draw[15:0];
			if (k == right)
				k = k ^ 16'h0001;   // Must not hit the real key
		end
		return k;
	endfunction

	// Ledger model where the balance only moves on OK
	function automatic logic [31:0] apply_model(input row_t r, input logic [31:0] amount);
		if (r.exp_code == BAD_ACCOUNT)
			return 32'd0;
		if (r.exp_code == OK && r.op == DEPOSIT)
			model_bal[r.acct] = model_bal[r.acct] + amount;
		else if (r.exp_code == OK && r.op == WITHDRAW)
			model_bal[r.acct] = model_bal[r.acct] - amount;
		return model_bal[r.acct];
	endfunction

	task automatic stop_on_timeout(input string what);
		$display("Timeout at %0t ns while waiting for %s", $time, what);
		timed_out = 1'b1;
		forever
			@(posedge clock);
	endtask

	task automatic check_code(input string name, input txn_code_e exp, input txn_code_e act);
		if (act !== exp)
		begin
			$display("** Error @ %0t ns: %s expected %s (%0d), got %s (%0d)",
				$time, name, exp.name(), exp, act.name(), act);
			err_count++;
		end
	endtask

	task automatic check_balance(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			$display("** Error @ %0t ns: %s expected %0d (0x%h), got %0d (0x%h)",
				$time, name, exp, exp, act, act);
			err_count++;
		end
	endtask

	task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
		if (act !== exp)
		begin
			$display("** Error @ %0t ns: %s expected %s, got %s (%b)",
				$time, name, exp.name(), act.name(), act);
			err_count++;
		end
	endtask

	// Called and left 1 ns after a rising edge
	task automatic axil_write(input logic [3:0] off, input logic [31:0] data,
			input int bready_hold, output axi_resp_e resp);
		bit aw_done;
		bit w_done;
		bit aw_hit;
		bit w_hit;
		bit b_done;
		int n;
		wr_req.awaddr = {28'h0, off};
		wr_req.awvalid = 1'b1;
		wr_req.wdata = data;
		wr_req.wstrb = 4'hF;
		wr_req.wvalid = 1'b1;
		aw_done = 1'b0;
		w_done = 1'b0;
		n = 0;
		while (!(aw_done && w_done) && n < HANDSHAKE_TIMEOUT)
		begin
			@(negedge clock);
			aw_hit = wr_req.awvalid && wr_rsp.awready;   // Fires on the coming edge
			w_hit = wr_req.wvalid && wr_rsp.wready;
			@(posedge clock);
			#1;
			if (aw_hit)
			begin
				wr_req.awvalid = 1'b0;
				aw_done = 1'b1;
			end
			if (w_hit)
			begin
				wr_req.wvalid = 1'b0;
				w_done = 1'b1;
			end
			n++;
		end
		if (!(aw_done && w_done))
			stop_on_timeout("AW and W handshakes");
		for (int c = 0; c < bready_hold; c++)
		begin
			@(posedge clock);
			#1;
		end
		wr_req.bready = 1'b1;
		b_done = 1'b0;
		resp = RESP_OKAY;
		n = 0;
		while (!b_done && n < HANDSHAKE_TIMEOUT)
		begin
			@(negedge clock);
			if (wr_rsp.bvalid)
			begin
				b_done = 1'b1;
				resp = wr_rsp.bresp;
			end
			@(posedge clock);
			#1;
			n++;
		end
		wr_req.bready = 1'b0;
		if (!b_done)
			stop_on_timeout("write response");
	endtask

	task automatic axil_read(input logic [3:0] off, input int rready_hold,
			output logic [31:0] data);
		bit ar_done;
		bit r_done;
		axi_resp_e resp;
		int n;
		rd_req.araddr = {28'h0, off};
		rd_req.arvalid = 1'b1;
		rd_req.rready = 1'b0;
		ar_done = 1'b0;
		n = 0;
		while (!ar_done && n < HANDSHAKE_TIMEOUT)
		begin
			@(negedge clock);
			ar_done = rd_rsp.arready;
			@(posedge clock);
			#1;
			n++;
		end
		rd_req.arvalid = 1'b0;
		if (!ar_done)
			stop_on_timeout("read address handshake");
		for (int c = 0; c < rready_hold; c++)
		begin
			@(posedge clock);
			#1;
		end
		rd_req.rready = 1'b1;
		r_done = 1'b0;
		data = '0;
		resp = RESP_OKAY;
		n = 0;
		while (!r_done && n < HANDSHAKE_TIMEOUT)
		begin
			@(negedge clock);
			if (rd_rsp.rvalid)
			begin
				r_done = 1'b1;
				data = rd_rsp.rdata;
				resp = rd_rsp.rresp;
			end
			@(posedge clock);
			#1;
			n++;
		end
		rd_req.rready = 1'b0;
		if (!r_done)
			stop_on_timeout("read data");
		check_resp("rresp", RESP_OKAY, resp);
	endtask

	task automatic wait_until_ready();
		logic [31:0] word;
		status_word_t st;
		bit seen;
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < POLL_LIMIT)
		begin
			axil_read(`LEDGER_REG_STATUS, 0, word);
			st = status_word_t'(word);
			seen = st.ready;
			n++;
		end
		if (!seen)
			stop_on_timeout("STATUS ready after reset");
	endtask

	task automatic wait_until_idle();
		logic [31:0] word;
		status_word_t st;
		bit idle;
		int n;
		idle = 1'b0;
		n = 0;
		while (!idle && n < POLL_LIMIT)
		begin
			axil_read(`LEDGER_REG_STATUS, 0, word);
			st = status_word_t'(word);
			idle = !st.busy;
			n++;
		end
		if (!idle)
			stop_on_timeout("STATUS busy to clear");
	endtask

	// Result is latched a cycle after busy drops, so STATUS is read again
	task automatic fetch_result(output txn_code_e code, output logic [31:0] bal);
		logic [31:0] word;
		status_word_t st;
		wait_until_idle();
		axil_read(`LEDGER_REG_STATUS, 0, word);
		st = status_word_t'(word);
		code = st.code;
		axil_read(`LEDGER_REG_BALANCE, 3, bal);   // Read data held back a few cycles
	endtask

	task automatic send_cmd(input txn_op_e op, input logic [`LEDGER_ACCT_W-1:0] acct,
			input logic [15:0] key, input int bready_hold, output axi_resp_e resp);
		cmd_word_t cw;
		cw = '{key: key, rsvd1: '0, account: acct, rsvd0: '0, op: op};
		axil_write(`LEDGER_REG_CMD, cw, bready_hold, resp);
	endtask

	task automatic report_test(input string what, input int errs_before);
		test_count++;
		if (err_count == errs_before)
		begin
			pass_count++;
			$display("test %0d %s: pass", test_count, what);
		end
		else
			$display("test %0d %s: FAIL", test_count, what);
	endtask

	task automatic run_row(input int i);
		row_t r;
		logic [31:0] amount;
		logic [31:0] exp_bal;
		logic [31:0] bal;
		logic [15:0] key;
		txn_code_e code;
		axi_resp_e resp;
		int errs_before;
		r = ROWS[i];
		amount = r.rand_amount ? random_bits(12) : r.amount;
		key = pick_key(r);
		errs_before = err_count;
		axil_write(`LEDGER_REG_AMOUNT, amount, 0, resp);
		check_resp("bresp of AMOUNT", RESP_OKAY, resp);
		send_cmd(r.op, r.acct, key, 0, resp);
		check_resp("bresp of CMD", RESP_OKAY, resp);
		fetch_result(code, bal);
		exp_bal = apply_model(r, amount);
		check_code("STATUS.code", r.exp_code, code);
		check_balance("BALANCE", exp_bal, bal);
		report_test($sformatf("row %0d %s account %0d", i, r.op.name(), r.acct), errs_before);
	endtask

	// Second command lands while the first runs and its response is stalled
	task automatic busy_write_test();
		axi_resp_e resp;
		txn_code_e code;
		logic [31:0] bal;
		int errs_before;
		errs_before = err_count;
		axil_write(`LEDGER_REG_AMOUNT, 32'd40, 0, resp);
		check_resp("bresp of AMOUNT", RESP_OKAY, resp);
		send_cmd(DEPOSIT, 3'd1, model_key[1], 0, resp);
		check_resp("bresp of CMD", RESP_OKAY, resp);
		send_cmd(WITHDRAW, 3'd2, model_key[2], 6, resp);
		check_resp("bresp of CMD while busy", RESP_SLVERR, resp);
		fetch_result(code, bal);
		model_bal[1] = model_bal[1] + 32'd40;
		check_code("STATUS.code", OK, code);
		check_balance("BALANCE", model_bal[1], bal);
		report_test("CMD write while busy", errs_before);
		errs_before = err_count;
		send_cmd(QUERY, 3'd2, model_key[2], 0, resp);
		check_resp("bresp of CMD", RESP_OKAY, resp);
		fetch_result(code, bal);
		check_code("STATUS.code", OK, code);
		check_balance("BALANCE", model_bal[2], bal);
		report_test("QUERY account 2 after refused CMD", errs_before);
	endtask

	initial
	begin
		int errs_before;
		int assert_fails;
		wr_req = '0;
		rd_req = '0;
		rst_n = 1'b0;
		rnd_state = RAND_SEED;
		err_count = 0;
		test_count = 0;
		pass_count = 0;
		for (int a = 0; a < `LEDGER_NUM_ACCOUNTS; a++)
		begin
			model_key[a] = key_after_steps(16 * (a + 1));
			model_bal[a] = `LEDGER_START_BALANCE;
		end
		repeat (5) @(posedge clock);
		#1;
		rst_n = 1'b1;

		errs_before = err_count;
		wait_until_ready();
		report_test("STATUS ready after reset", errs_before);

		for (int i = 0; i < NUM_ROWS; i++)
			run_row(i);
		busy_write_test();

		assert_fails = dut_i.assert_i.fail_count;
		$display("%0d tests, %0d passed, %0d failed, %0d check errors, %0d assertion failures",
			test_count, pass_count, test_count - pass_count, err_count, assert_fails);
		if (err_count == 0 && assert_fails == 0 && pass_count == test_count)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+hw
hw/ledger_pkg.sv
hw/axil_regs.sv
hw/txn_control.sv
hw/key_table.sv
hw/account_ram.sv
hw/balance_datapath.sv
hw/ledger_top.sv
testbench/ledger_assertions.sv
testbench/tb_ledger.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_ledger -f files.f -o tb_ledger
	./obj_dir/tb_ledger +verilator+error+limit+100 | \
		awk '{ print } /^TESTS PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
